//--- Bender.yml
package:
  name: obj_engine

sources:
  - files:
      - logic/obj_pkg.sv
      - logic/obj_table_ram.sv
      - logic/obj_tile_match.sv
      - logic/obj_scan.sv
      - logic/obj_line_draw.sv
      - logic/obj_line_buffer.sv
      - logic/obj_engine.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/obj_engine_tb.sv

//--- logic/obj_engine.sv
`timescale 1ns/1ps

module obj_engine #(
    parameter int TABLE_AW = 10
) (
    input  logic               clk,
    input  logic               rst,
    input  obj_pkg::wb_req_t   wb_req,
    output obj_pkg::wb_rsp_t   wb_rsp,
    input  logic               flip,
    input  logic [8:0]         vrender,
    input  logic [8:0]         hdump,
    input  logic [9:0]         off_x,
    input  logic [9:0]         off_y,
    output logic               line,
    output logic               scan_busy,
    output obj_pkg::line_pix_t pix
);

    logic [TABLE_AW-1:0] table_addr;
    obj_pkg::obj_entry_u table_entry;
    logic                dr_start;
    obj_pkg::draw_req_t  dr_req;
    logic                dr_idle;
    logic                wr_en;
    logic [8:0]          wr_addr;
    obj_pkg::line_pix_t  wr_pix;

    obj_table_ram #(
        .TABLE_AW (TABLE_AW)
    ) u_table (
        .clk         (clk),
        .rst         (rst),
        .wb_req      (wb_req),
        .wb_rsp      (wb_rsp),
        .table_addr  (table_addr),
        .table_entry (table_entry)
    );

    obj_scan #(
        .TABLE_AW (TABLE_AW)
    ) u_scan (
        .clk         (clk),
        .rst         (rst),
        .flip        (flip),
        .vrender     (vrender),
        .hdump       (hdump),
        .off_x       (off_x),
        .off_y       (off_y),
        .line        (line),
        .scan_busy   (scan_busy),
        .table_addr  (table_addr),
        .table_entry (table_entry),
        .dr_start    (dr_start),
        .dr_req      (dr_req),
        .dr_idle     (dr_idle)
    );

    obj_line_draw u_draw (
        .clk      (clk),
        .rst      (rst),
        .dr_start (dr_start),
        .dr_req   (dr_req),
        .dr_idle  (dr_idle),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_pix   (wr_pix)
    );

    obj_line_buffer u_buffer (
        .clk     (clk),
        .rst     (rst),
        .line    (line),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_pix  (wr_pix),
        .hdump   (hdump),
        .pix     (pix)
    );

endmodule

//--- logic/obj_line_buffer.sv
`timescale 1ns/1ps

module obj_line_buffer (
    input  logic               clk,
    input  logic               rst,
    input  logic               line,
    input  logic               wr_en,
    input  logic [8:0]         wr_addr,
    input  obj_pkg::line_pix_t wr_pix,
    input  logic [8:0]         hdump,
    output obj_pkg::line_pix_t pix
);

    obj_pkg::line_pix_t mem [2][512];
    logic [1:0][511:0]  vld;      // valid flags kept apart so reset empties both halves
    logic               rd_half;
    obj_pkg::line_pix_t stored;
    obj_pkg::line_pix_t rd_word;
    logic               rd_vld;
    logic               wr_take;

    assign rd_half = ~line;  // drawing goes to half `line`

    // equal priority lets the later object win
    assign stored  = mem[line][wr_addr];
    assign wr_take = wr_en && (!vld[line][wr_addr] || stored.prio <= wr_pix.prio);

    always_ff @(posedge clk) begin
        rd_word <= mem[rd_half][hdump];
        if (wr_take) begin
            mem[line][wr_addr] <= wr_pix;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vld    <= '0;
            rd_vld <= 1'b0;
        end else begin
            rd_vld <= vld[rd_half][hdump];
            vld[rd_half][hdump] <= 1'b0;  // cleared right behind the read
            if (wr_take) begin
                vld[line][wr_addr] <= 1'b1;
            end
        end
    end

    assign pix = rd_vld ? rd_word : '0;

endmodule

//--- logic/obj_line_draw.sv
`timescale 1ns/1ps

module obj_line_draw (
    input  logic               clk,
    input  logic               rst,
    input  logic               dr_start,
    input  obj_pkg::draw_req_t dr_req,
    output logic               dr_idle,
    output logic               wr_en,
    output logic [8:0]         wr_addr,
    output obj_pkg::line_pix_t wr_pix
);

    obj_pkg::draw_req_t req;
    logic               busy;
    logic [3:0]         cnt;
    logic [3:0]         offs;
    logic [9:0]         addr;

    assign dr_idle = !busy;

    // mirrored tiles walk from the right edge
    assign offs = req.hflip ? ~cnt : cnt;
    assign addr = {1'b0, req.hpos} + {6'd0, offs};

    assign wr_en   = busy && !addr[9];  // past the line end
    assign wr_addr = addr[8:0];

    // flat tile colour from the code
    assign wr_pix = '{
        valid:   1'b1,
        prio:    req.prio,
        bank:    req.bank,
        palette: req.palette,
        colour:  req.code[3:0]
    };

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (busy) begin
            cnt <= cnt + 1'b1;
            if (cnt == 4'd15) begin
                busy <= 1'b0;
            end
        end else if (dr_start) begin
            busy <= 1'b1;
            cnt  <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (dr_start && !busy) begin
            req <= dr_req;
        end
    end

    sixteen_pixels: assert property (
        @(posedge clk) disable iff (rst)
        dr_start && dr_idle |=> !dr_idle [*16] ##1 dr_idle
    ) else $error("draw did not take exactly 16 clocks");

endmodule

//--- logic/obj_pkg.sv
package obj_pkg;

    // one table slot, x in the low word so the raw view indexes x as word 0
    typedef struct packed {
        logic [15:0] attr;  // rows-1, cols-1, abs, vflip, hflip, palette
        logic [15:0] code;
        logic [15:0] y;     // end mark, bank, position
        logic [15:0] x;     // priority, position
    } obj_entry_t;

    // the CPU sees four plain words, the scanner sees fields
    typedef union packed {
        obj_entry_t       f;
        logic [3:0][15:0] w;  // w[0] x .. w[3] attr
    } obj_entry_u;

    typedef struct packed {
        logic [15:0] code;
        logic [3:0]  vsub;     // pixel row inside the tile
        logic [8:0]  hpos;
        logic [4:0]  palette;
        logic        hflip;
        logic [2:0]  prio;
        logic [1:0]  bank;
    } draw_req_t;

    typedef struct packed {
        logic       valid;
        logic [2:0] prio;
        logic [1:0] bank;
        logic [4:0] palette;
        logic [3:0] colour;
    } line_pix_t;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [11:0] adr;    // entry index above, word select in [1:0]
        logic [15:0] dat_w;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [15:0] dat_r;
    } wb_rsp_t;

    localparam logic [8:0] SCAN_START_H = 9'h1d0;
    localparam logic [9:0] OBJ_X_BIAS   = 10'h040;
    localparam logic [9:0] OBJ_Y_BIAS   = 10'h010;

endpackage

//--- logic/obj_scan.sv
`timescale 1ns/1ps

module obj_scan #(
    parameter int TABLE_AW = 10
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                flip,
    input  logic [8:0]          vrender,
    input  logic [8:0]          hdump,
    input  logic [9:0]          off_x,
    input  logic [9:0]          off_y,
    output logic                line,
    output logic                scan_busy,
    output logic [TABLE_AW-1:0] table_addr,
    input  obj_pkg::obj_entry_u table_entry,
    output logic                dr_start,
    output obj_pkg::draw_req_t  dr_req,
    input  logic                dr_idle
);

    obj_pkg::obj_entry_t ent;
    obj_pkg::obj_entry_t st3_entry;
    obj_pkg::obj_entry_t match_entry;
    logic                cen;
    logic                start;
    logic                last_start;
    logic                done;
    logic                ent_end;
    logic [8:0]          vrenderf;
    logic                st3_valid;
    logic [9:0]          st3_x;
    logic [9:0]          st3_y;
    logic [9:0]          match_y;
    logic [9:0]          st4_x;
    logic [3:0]          st4_cols;
    logic                st4_hflip;
    logic [4:0]          st4_pal;
    logic [2:0]          st4_prio;
    logic [1:0]          st4_bank;
    logic                inzone;
    logic [3:0]          st4_vsub;
    logic [15:0]         code_row;
    logic [3:0]          col;       // tile column being issued
    logic                last_col;
    logic [3:0]          subn;
    logic [9:0]          effx;
    logic                stall;
    logic                issue;

    obj_tile_match u_match (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen && !stall),
        .entry    (match_entry),
        .vrenderf (vrenderf),
        .obj_y    (match_y),
        .inzone   (inzone),
        .vsub     (st4_vsub),
        .code_row (code_row)
    );

    assign ent     = table_entry.f;
    assign ent_end = ent.y[15] || ent.attr[15:8] == 8'hff;
    assign start   = hdump == obj_pkg::SCAN_START_H;

    // an empty slot is blanked and pushed far below any line so it never matches
    assign match_entry = st3_valid ? st3_entry : '0;
    assign match_y     = st3_valid ? st3_y : 10'h200;

    assign last_col = col == st4_cols;
    assign subn     = st4_hflip ? st4_cols - col : col;
    assign effx     = st4_x + {2'b0, subn, 4'd0};
    assign stall    = inzone && (!dr_idle || !last_col);
    assign issue    = cen && inzone && dr_idle;

    assign scan_busy = !done || st3_valid || inzone || dr_start || !dr_idle;

    // the table port is registered, so every step waits one extra clock
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cen <= 1'b0;
        end else begin
            cen <= ~cen;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            table_addr <= '0;
            done       <= 1'b1;
            st3_valid  <= 1'b0;
            col        <= '0;
            line       <= 1'b0;
            last_start <= 1'b0;
            vrenderf   <= '0;
            dr_start   <= 1'b0;
        end else if (cen) begin
            last_start <= start;
            if (!stall) begin
                table_addr <= done ? '0 : table_addr + 1'b1;
                if (done || ent_end) begin
                    done      <= 1'b1;
                    st3_valid <= 1'b0;
                end else begin
                    st3_valid <= 1'b1;
                    done      <= &table_addr;  // last slot taken
                end
            end
            dr_start <= inzone && dr_idle && !effx[9];  // off-screen tiles skipped
            if (inzone && dr_idle) begin
                col <= last_col ? '0 : col + 1'b1;
            end
            // new line wins over everything above
            if (start && !last_start) begin
                line       <= ~line;
                vrenderf   <= vrender ^ {1'b0, {8{flip}}};
                done       <= 1'b0;
                table_addr <= '0;
                col        <= '0;
            end
        end else begin
            dr_start <= 1'b0;  // one clock wide
        end
    end

    always_ff @(posedge clk) begin
        if (cen && !stall) begin
            st3_entry <= ent;
            st3_x     <= ent.x[9:0] + obj_pkg::OBJ_X_BIAS - (ent.attr[7] ? 10'd0 : off_x);
            st3_y     <= ent.y[9:0] + obj_pkg::OBJ_Y_BIAS - (ent.attr[7] ? 10'd0 : off_y);
            st4_x     <= st3_x;
            st4_cols  <= st3_entry.attr[11:8];
            st4_hflip <= st3_entry.attr[5];
            st4_pal   <= st3_entry.attr[4:0];
            st4_prio  <= st3_entry.x[15:13];
            st4_bank  <= st3_entry.y[14:13];
        end
        if (issue) begin
            dr_req.code    <= code_row + {12'd0, col};
            dr_req.vsub    <= st4_vsub;
            dr_req.hpos    <= effx[8:0] - 9'd1;
            dr_req.palette <= st4_pal;
            dr_req.hflip   <= st4_hflip;
            dr_req.prio    <= st4_prio;
            dr_req.bank    <= st4_bank;
        end
    end

    start_only_when_idle: assert property (
        @(posedge clk) disable iff (rst)
        dr_start |-> dr_idle
    ) else $error("draw start while the draw unit is busy");

endmodule

//--- logic/obj_table_ram.sv
`timescale 1ns/1ps

module obj_table_ram #(
    parameter int TABLE_AW = 10
) (
    input  logic                clk,
    input  logic                rst,
    input  obj_pkg::wb_req_t    wb_req,
    output obj_pkg::wb_rsp_t    wb_rsp,
    input  logic [TABLE_AW-1:0] table_addr,
    output obj_pkg::obj_entry_u table_entry
);

    localparam int DEPTH = 1 << TABLE_AW;

    logic [15:0]         words [4][DEPTH];  // x, y, code, attr planes
    logic [TABLE_AW-1:0] wb_idx;
    logic [1:0]          wb_sel;
    logic                wb_hit;
    logic                ack_q;
    logic [15:0]         dat_q;

    assign wb_idx = wb_req.adr[TABLE_AW+1:2];
    assign wb_sel = wb_req.adr[1:0];
    assign wb_hit = wb_req.cyc && wb_req.stb && !ack_q;  // held request counts once

    always_ff @(posedge clk) begin
        if (wb_hit && wb_req.we) begin
            words[wb_sel][wb_idx] <= wb_req.dat_w;
        end
        dat_q <= words[wb_sel][wb_idx];
        // scanner port, whole entry per address
        for (int k = 0; k < 4; k++) begin
            table_entry.w[k] <= words[k][table_addr];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= wb_hit;
        end
    end

    assign wb_rsp = '{ack: ack_q, dat_r: dat_q};

    ack_needs_strobe: assert property (
        @(posedge clk) disable iff (rst)
        $rose(ack_q) |-> $past(wb_req.cyc && wb_req.stb)
    ) else $error("table ack raised without cyc and stb");

endmodule

//--- logic/obj_tile_match.sv
`timescale 1ns/1ps

module obj_tile_match (
    input  logic                clk,
    input  logic                rst,
    input  logic                cen,
    input  obj_pkg::obj_entry_t entry,
    input  logic [8:0]          vrenderf,
    input  logic [9:0]          obj_y,
    output logic                inzone,
    output logic [3:0]          vsub,
    output logic [15:0]         code_row
);

    logic [3:0] rows_m1;
    logic       vflip;
    logic [9:0] height;
    logic [9:0] dy;
    logic       hit;
    logic [3:0] row;
    logic [3:0] sub;

    assign rows_m1 = entry.attr[15:12];
    assign vflip   = entry.attr[6];

    // 16 lines per tile row
    assign height = {1'b0, {1'b0, rows_m1} + 5'd1, 4'd0};

    // wraps to a large value when the line sits above the object
    assign dy  = {1'b0, vrenderf} - obj_y;
    assign hit = dy < height;

    always_comb begin
        if (vflip) begin
            row = rows_m1 - dy[7:4];  // count rows from the bottom
            sub = ~dy[3:0];
        end else begin
            row = dy[7:4];
            sub = dy[3:0];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            inzone <= 1'b0;
        end else if (cen) begin
            inzone <= hit;
        end
    end

    always_ff @(posedge clk) begin
        if (cen) begin
            vsub     <= sub;
            code_row <= entry.code + {8'd0, row, 4'd0};  // next tile row is 16 codes on
        end
    end

endmodule

//--- obj_engine.f
+incdir+verification
logic/obj_pkg.sv
logic/obj_table_ram.sv
logic/obj_tile_match.sv
logic/obj_scan.sv
logic/obj_line_draw.sv
logic/obj_line_buffer.sv
logic/obj_engine.sv
verification/obj_engine_tb.sv

//--- verification/obj_engine_checks.svh
`ifndef OBJ_ENGINE_CHECKS_SVH
`define OBJ_ENGINE_CHECKS_SVH

// next value of the random sequence
function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
endfunction

task automatic check_wb_rsp(input string name, input obj_pkg::wb_rsp_t got,
                            input obj_pkg::wb_rsp_t exp);
    if (got !== exp) begin
        abort_run($sformatf("** Error at %0t: %s ack=%b dat_r=%h, expected ack=%b dat_r=%h",
                            $time, name, got.ack, got.dat_r, exp.ack, exp.dat_r));
    end
endtask

task automatic check_pix(input string name, input obj_pkg::line_pix_t got,
                         input obj_pkg::line_pix_t exp);
    if (got !== exp) begin
        abort_run($sformatf("** Error at %0t: %s = %h, expected %h", $time, name, got, exp));
    end
endtask

// single control bits such as line and scan_busy
task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        abort_run($sformatf("** Error at %0t: %s = %b, expected %b", $time, name, got, exp));
    end
endtask

`endif

//--- verification/obj_engine_tb.sv
`timescale 1ns/1ps

module obj_engine_tb;

    localparam int ACK_TIMEOUT  = 20;    // clocks
    localparam int BUSY_TIMEOUT = 4000;

    logic               clk;
    logic               rst;
    obj_pkg::wb_req_t   wb_req;
    obj_pkg::wb_rsp_t   wb_rsp;
    logic               flip;
    logic [8:0]         vrender;
    logic [8:0]         hdump;
    logic [9:0]         off_x;
    logic [9:0]         off_y;
    logic               line;
    logic               scan_busy;
    obj_pkg::line_pix_t pix;
    obj_pkg::line_pix_t exp_pix [512];  // expected words of the line being read out
    logic               exp_set [512];
    logic [31:0]        rnd;
    int                 errors;

    obj_engine #(
        .TABLE_AW (10)
    ) obj_engine_inst (
        .clk       (clk),
        .rst       (rst),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .flip      (flip),
        .vrender   (vrender),
        .hdump     (hdump),
        .off_x     (off_x),
        .off_y     (off_y),
        .line      (line),
        .scan_busy (scan_busy),
        .pix       (pix)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    task automatic abort_run(input string why);
        errors++;
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    `include "obj_engine_checks.svh"

    task automatic idle_gap();
        rnd = lcg_next(rnd);
        repeat (rnd[17:16]) begin
            @(posedge clk);
            #2;
        end
    endtask

    // one Wishbone cycle, read data compared with dat
    task automatic wb_access(input logic we, input logic [11:0] adr, input logic [15:0] dat);
        int n;
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat_w: dat};
        n = 0;
        do begin
            @(posedge clk);
            #2;
            n++;
        end while (!wb_rsp.ack && n < ACK_TIMEOUT);
        if (!wb_rsp.ack) begin
            abort_run($sformatf("no Wishbone ack for address %h", adr));
        end
        if (!we) begin
            check_wb_rsp("wb_rsp", wb_rsp, '{ack: 1'b1, dat_r: dat});
        end
        wb_req = '0;
        @(posedge clk);
        #2;
        check_bit("wb_rsp.ack", wb_rsp.ack, 1'b0);  // ack one clock only
    endtask

    task automatic write_and_verify(input logic [11:0] adr, input logic [15:0] dat);
        wb_access(1'b1, adr, dat);
        idle_gap();
        wb_access(1'b0, adr, dat);
    endtask

    // starts at the scan start, so the whole line comes from one buffer half
    task automatic sweep_line(input logic [8:0] v, input logic [9:0] ox, input logic [9:0] oy,
                              input logic fl);
        logic [8:0] h;
        logic       line_before;
        int         i;
        int         n;
        line_before = line;
        vrender = v;
        off_x   = ox;
        off_y   = oy;
        flip    = fl;
        for (i = 0; i < 512; i++) begin
            h = obj_pkg::SCAN_START_H + 9'(i);
            hdump = h;
            @(posedge clk);
            #2;
            if (exp_set[h]) begin
                check_pix($sformatf("pix[%h]", h), pix, exp_pix[h]);
            end
            @(posedge clk);  // held two clocks, one of them a scan enable
            #2;
            if (i == 0) begin
                check_bit("scan_busy", scan_busy, 1'b1);  // table walk under way
            end
        end
        check_bit("line", line, !line_before);
        n = 0;
        while (scan_busy && n < BUSY_TIMEOUT) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (scan_busy) begin
            abort_run("scan_busy did not fall after the line scan");
        end
        for (i = 0; i < 512; i++) begin
            exp_set[i] = 1'b0;
        end
    endtask

    initial begin
        int    fd;
        int    code;
        int    a;
        int    d;
        int    v;
        int    ox;
        int    oy;
        int    fl;
        int    e;
        int    w;
        byte   kind;
        string text;
        rst     = 1'b1;
        wb_req  = '0;
        flip    = 1'b0;
        vrender = '0;
        hdump   = '0;
        off_x   = '0;
        off_y   = '0;
        errors  = 0;
        rnd     = 32'd10;
        for (e = 0; e < 512; e++) begin
            exp_set[e] = 1'b0;
        end
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;
        @(posedge clk);
        #2;
        check_bit("line", line, 1'b0);
        check_bit("scan_busy", scan_busy, 1'b0);
        check_pix("pix", pix, '0);

        // slots past every end mark hold junk
        for (e = 2; e < 16; e++) begin
            for (w = 0; w < 4; w++) begin
                rnd = lcg_next(rnd);
                wb_access(1'b1, {e[9:0], w[1:0]}, rnd[31:16]);
                idle_gap();
            end
        end

        fd = $fopen("verification/obj_engine_tests.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open the test data file");
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, " %c", kind);
            if (code != 1) begin
                break;
            end
            case (kind)
                "#": code = $fgets(text, fd);
                "W": begin
                    code = $fscanf(fd, " %h %h", a, d);
                    if (code != 2) abort_run("malformed W record in the test data file");
                    write_and_verify(12'(a), 16'(d));
                end
                "L": begin
                    code = $fscanf(fd, " %h %h %h %h", v, ox, oy, fl);
                    if (code != 4) abort_run("malformed L record in the test data file");
                    sweep_line(9'(v), 10'(ox), 10'(oy), fl[0]);  // checks the line before
                end
                "P": begin
                    code = $fscanf(fd, " %h %h", a, d);
                    if (code != 2) abort_run("malformed P record in the test data file");
                    exp_pix[a[8:0]] = 15'(d);
                    exp_set[a[8:0]] = 1'b1;
                end
                default: abort_run($sformatf("unknown record type %c in the test data", kind));
            endcase
        end
        $fclose(fd);
        sweep_line(9'h1f0, '0, '0, 1'b0);  // reads out the last line

        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- verification/obj_engine_tests.txt
# W adr data: table word write | L vrender off_x off_y flip: scan one line
# P x word: expected line_pix_t at x of the line from the L record above
W 000 0010
W 001 0020
W 002 0005
W 003 0003
W 005 8000
L 035 000 000 0
P 04e 0000
P 04f 4035
P 05e 4035
P 05f 0000
L 060 000 000 0
P 04f 0000
L 02f 000 000 0
P 04f 0000
# 3 columns by 2 rows, second tile row on the line
W 000 4080
W 001 2040
W 002 0021
W 003 1207
L 063 000 000 0
P 0be 0000
P 0bf 5271
P 0ce 5271
P 0cf 5272
P 0df 5273
P 0ee 5273
P 0ef 0000
W 003 1227
L 063 000 000 0
P 0bf 5273
P 0cf 5272
P 0ee 5271
# absolute object next to a scrolled one, end mark in entry 2
W 000 0010
W 001 0020
W 002 0009
W 003 0084
W 004 0100
W 005 0020
W 006 000a
W 007 0006
W 009 8000
L 035 020 008 0
P 04f 4049
P 11e 0000
P 11f 406a
P 12e 406a
# entry 1 loses under entry 0, entry 2 wins over both
W 000 2010
W 002 0001
W 003 0001
W 004 0018
W 006 0002
W 007 0002
W 008 201c
W 009 0020
W 00a 0003
W 00b 0003
W 00d 8000
L 035 000 000 0
P 04f 4811
P 057 4811
P 05a 4811
P 05b 4833
P 06a 4833
P 06b 0000
L 060 000 000 0
L 060 000 000 0
P 04f 0000
P 05b 0000
